// File: verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef enum logic [2:0] {
        alu_add, alu_adc, alu_sub, alu_sbc,
        alu_and, alu_xor, alu_or, alu_cp
    } alu_op_e;

    typedef enum logic [1:0] {cond_nz, cond_z, cond_nc, cond_c} cond_e;

    // 01 ddd sss, 10 ooo sss and friends
    typedef struct packed {
        logic [1:0] group;
        logic [2:0] dst;
        logic [2:0] src;
    } ld_fields_t;

    // 110 cc 010 for conditional jumps
    typedef struct packed {
        logic [1:0] group;
        logic       spare;
        cond_e      cond;
        logic [2:0] low;
    } cond_fields_t;

    typedef union packed {
        ld_fields_t   ld_fields;
        cond_fields_t cond_fields;
    } opcode_u;

    localparam logic [2:0] reg_h   = 3'd4;
    localparam logic [2:0] reg_l   = 3'd5;
    localparam logic [2:0] reg_mem = 3'd6;   // (HL) operand, no register behind it
    localparam logic [2:0] reg_a   = 3'd7;

    localparam logic [7:0] op_jp   = 8'hc3;
    localparam logic [7:0] op_halt = 8'h76;

    localparam int flag_z_bit = 3;
    localparam int flag_n_bit = 2;
    localparam int flag_h_bit = 1;
    localparam int flag_c_bit = 0;

endpackage

`default_nettype wire

// File: verilog/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    // One clock per step
    typedef enum logic [2:0] {
        step_fetch,
        step_exec,
        step_imm,      // ALU A,n compute after operand read
        step_addr_hi,
        step_addr_lo,
        step_mem,
        step_jump,
        step_halt
    } step_e;

    typedef enum logic [1:0] {
        addr_sel_pc,
        addr_sel_buf
    } addr_sel_e;

    typedef enum logic [1:0] {
        wdata_sel_bus,
        wdata_sel_alu,
        wdata_sel_out2
    } wdata_sel_e;

    typedef enum logic {
        bsrc_sel_out2,
        bsrc_sel_data
    } bsrc_sel_e;

endpackage

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire [7:0]          a,
    input  wire [7:0]          b,
    input  wire isa_pkg::alu_op_e op,
    input  wire                carry_in,
    output logic [7:0]         result,
    output logic [3:0]         flags_out
);
    import isa_pkg::*;

    logic       cin;
    logic [8:0] wide;
    logic [4:0] half;

    // Carry only enters on adc and sbc
    assign cin = carry_in & ((op == alu_adc) | (op == alu_sbc));

    always_comb
    begin
        half = 5'd0;
        flags_out = 4'd0;
        case (op)
            alu_add, alu_adc:
            begin
                wide = {1'b0, a} + {1'b0, b} + {8'd0, cin};
                half = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin};
                flags_out[flag_h_bit] = half[4];
                flags_out[flag_c_bit] = wide[8];
            end
            alu_sub, alu_sbc, alu_cp:
            begin
                wide = {1'b0, a} - {1'b0, b} - {8'd0, cin};
                half = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, cin};
                flags_out[flag_n_bit] = 1'b1;
                flags_out[flag_h_bit] = half[4];   // Borrow out of bit 3
                flags_out[flag_c_bit] = wide[8];
            end
            alu_and:
            begin
                wide = {1'b0, a & b};
                flags_out[flag_h_bit] = 1'b1;
            end
            alu_xor: wide = {1'b0, a ^ b};
            default: wide = {1'b0, a | b};
        endcase
        flags_out[flag_z_bit] = (wide[7:0] == 8'd0);
    end

    assign result = wide[7:0];

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  wire       clock,
    input  wire       rst,
    input  wire [2:0] out1_sel,
    input  wire [2:0] out2_sel,
    input  wire [2:0] wr_sel,
    input  wire [7:0] data_in,
    input  wire       write_reg,
    output logic [7:0] out1,
    output logic [7:0] out2
);
    import isa_pkg::*;

    logic [7:0] regs [8];   // B C D E H L - A

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int i = 0; i < 8; i++)
            begin
                regs[i] <= 8'd0;
            end
        end
        else if (write_reg)
        begin
            regs[wr_sel] <= data_in;
        end
    end

    assign out1 = regs[out1_sel];
    assign out2 = regs[out2_sel];

    // Decoder never targets the (HL) slot
    no_mem_write: assert property (@(posedge clock) disable iff (rst)
        write_reg |-> (wr_sel != reg_mem));

endmodule

`default_nettype wire

// File: verilog/program_counter.sv
`timescale 1ns/1ns
`default_nettype none

module program_counter #(
    parameter logic [15:0] RESET_VECTOR = 16'h0000
) (
    input  wire        clock,
    input  wire        rst,
    input  wire        increment,
    input  wire        load,
    input  wire [15:0] load_value,
    output logic [15:0] pc
);

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            pc <= RESET_VECTOR;
        end
        else if (load)
        begin
            pc <= load_value;   // Taken jump
        end
        else if (increment)
        begin
            pc <= pc + 16'd1;
        end
    end

    // Jump step never reads the bus
    inc_load_excl: assert property (@(posedge clock) disable iff (rst) !(increment && load));

endmodule

`default_nettype wire

// File: verilog/control_unit.sv
`timescale 1ns/1ns
`default_nettype none

module control_unit (
    input  wire                     clock,
    input  wire                     rst,
    input  wire isa_pkg::opcode_u   opcode,
    input  wire                     cond_true,
    output logic [2:0]              out1_sel,
    output logic [2:0]              out2_sel,
    output logic [2:0]              wr_sel,
    output logic                    write_reg,
    output isa_pkg::alu_op_e        alu_op,
    output ctrl_pkg::bsrc_sel_e     bsrc_sel,
    output ctrl_pkg::wdata_sel_e    wdata_sel,
    output logic                    flag_write,
    output logic                    pc_increment,
    output logic                    pc_load,
    output logic                    inst_write,
    output logic                    addr_write,
    output logic                    data_write,
    output ctrl_pkg::addr_sel_e     addr_sel,
    output logic                    nread,
    output logic                    nwrite,
    output logic                    halted
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    step_e      step;
    step_e      next_step;
    step_e      first_step;
    step_e      cur_step;
    logic [1:0] group;
    logic [2:0] dst;
    logic [2:0] src;
    logic       is_ld_rr;
    logic       is_ld_rn;
    logic       is_ld_st;
    logic       is_ld_ld;
    logic       is_alu_r;
    logic       is_alu_n;
    logic       is_jp;
    logic       is_jpcc;
    logic       is_halt;
    logic       alu_wr;

    assign group = opcode.ld_fields.group;
    assign dst   = opcode.ld_fields.dst;
    assign src   = opcode.ld_fields.src;

    assign is_halt  = (opcode == op_halt);
    assign is_ld_rr = (group == 2'b01) && (dst != reg_mem) && (src != reg_mem);
    assign is_ld_st = (group == 2'b01) && (dst == reg_mem) && (src != reg_mem);
    assign is_ld_ld = (group == 2'b01) && (src == reg_mem) && (dst != reg_mem);
    assign is_ld_rn = (group == 2'b00) && (src == reg_mem) && (dst != reg_mem);
    assign is_alu_r = (group == 2'b10) && (src != reg_mem);
    assign is_alu_n = (group == 2'b11) && (src == reg_mem);
    assign is_jp    = (opcode == op_jp);
    assign is_jpcc  = (group == 2'b11) && !opcode.cond_fields.spare
                      && (opcode.cond_fields.low == 3'b010);

    assign alu_op = alu_op_e'(dst);
    assign alu_wr = (alu_op != alu_cp);   // cp only sets flags

    // What the cycle after fetch really does
    always_comb
    begin
        if (is_jp || is_jpcc || is_ld_st || is_ld_ld)
            first_step = step_addr_hi;
        else if (is_halt)
            first_step = step_halt;
        else if (is_ld_rr || is_ld_rn || is_alu_r || is_alu_n)
            first_step = step_exec;
        else
            first_step = step_fetch;   // Unknown opcode, overlap next fetch
    end

    assign cur_step = (step == step_exec) ? first_step : step;

    always_comb
    begin
        out1_sel = reg_a;
        out2_sel = src;
        wr_sel = dst;
        write_reg = 1'b0;
        bsrc_sel = bsrc_sel_out2;
        wdata_sel = wdata_sel_out2;
        flag_write = 1'b0;
        pc_increment = 1'b0;
        pc_load = 1'b0;
        inst_write = 1'b0;
        addr_write = 1'b0;
        data_write = 1'b0;
        addr_sel = addr_sel_pc;
        nread = 1'b1;
        nwrite = 1'b1;
        next_step = step_fetch;
        case (cur_step)
            step_fetch:
            begin
                nread = 1'b0;
                inst_write = 1'b1;
                pc_increment = 1'b1;
                next_step = step_exec;
            end
            step_exec:
            begin
                if (is_ld_rr)
                begin
                    write_reg = 1'b1;
                end
                else if (is_ld_rn)
                begin
                    nread = 1'b0;
                    wdata_sel = wdata_sel_bus;
                    write_reg = 1'b1;
                    pc_increment = 1'b1;
                end
                else if (is_alu_r)
                begin
                    wr_sel = reg_a;
                    wdata_sel = wdata_sel_alu;
                    write_reg = alu_wr;
                    flag_write = 1'b1;
                end
                else
                begin
                    nread = 1'b0;   // Immediate operand of ALU A,n
                    data_write = 1'b1;
                    pc_increment = 1'b1;
                    next_step = step_imm;
                end
            end
            step_imm:
            begin
                wr_sel = reg_a;
                bsrc_sel = bsrc_sel_data;
                wdata_sel = wdata_sel_alu;
                write_reg = alu_wr;
                flag_write = 1'b1;
            end
            step_addr_hi, step_addr_lo:
            begin
                addr_write = 1'b1;
                if (is_jp || is_jpcc)
                begin
                    nread = 1'b0;
                    pc_increment = 1'b1;
                end
                else
                begin
                    out2_sel = (cur_step == step_addr_hi) ? reg_h : reg_l;
                    addr_sel = addr_sel_buf;   // Buffer takes out2
                end
                if (cur_step == step_addr_hi)
                    next_step = step_addr_lo;
                else
                    next_step = (is_jp || is_jpcc) ? step_jump : step_mem;
            end
            step_mem:
            begin
                addr_sel = addr_sel_buf;
                if (is_ld_st)
                begin
                    nwrite = 1'b0;
                end
                else
                begin
                    nread = 1'b0;
                    wdata_sel = wdata_sel_bus;
                    write_reg = 1'b1;
                end
            end
            step_jump: pc_load = is_jp || (is_jpcc && cond_true);
            default: next_step = step_halt;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (rst)
            step <= step_jump;   // Idle step, opcode is a cleared nop
        else
            step <= next_step;
    end

    assign halted = (step == step_halt);

    no_bus_clash: assert property (@(posedge clock) disable iff (rst) nread || nwrite);

endmodule

`default_nettype wire

// File: verilog/bus_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module bus_datapath (
    input  wire                     clock,
    input  wire                     rst,
    input  wire [7:0]               data_in,
    input  wire [7:0]               out2,
    input  wire [3:0]               alu_flags,
    input  wire [15:0]              pc,
    input  wire                     inst_write,
    input  wire                     addr_write,
    input  wire                     data_write,
    input  wire                     flag_write,
    input  wire ctrl_pkg::addr_sel_e addr_sel,
    output isa_pkg::opcode_u        opcode,
    output logic [7:0]              data_buffer,
    output logic [15:0]             address,
    output logic [7:0]              data_out,
    output logic [3:0]              flags,
    output logic                    cond_true,
    output logic [15:0]             jump_target
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic [15:0] addr_buffer;
    logic [7:0]  shift_in;

    // Operand bytes when reading at PC, else H or L from out2
    assign shift_in = (addr_sel == addr_sel_pc) ? data_in : out2;

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            opcode <= '0;
            flags <= 4'd0;
        end
        else
        begin
            if (inst_write)
                opcode <= data_in;
            if (flag_write)
                flags <= alu_flags;
        end
    end

    always_ff @(posedge clock)
    begin
        if (addr_write)
            addr_buffer <= {addr_buffer[7:0], shift_in};   // High byte first
        if (data_write)
            data_buffer <= data_in;
    end

    always_comb
    begin
        case (opcode.cond_fields.cond)
            cond_nz: cond_true = !flags[flag_z_bit];
            cond_z:  cond_true = flags[flag_z_bit];
            cond_nc: cond_true = !flags[flag_c_bit];
            default: cond_true = flags[flag_c_bit];
        endcase
    end

    assign address = (addr_sel == addr_sel_buf) ? addr_buffer : pc;
    assign data_out = out2;
    assign jump_target = addr_buffer;

endmodule

`default_nettype wire

// File: verilog/cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core #(
    parameter logic [15:0] RESET_VECTOR = 16'h0000
) (
    input  wire        clock,
    input  wire        rst,
    input  wire [7:0]  data_in,
    output logic [15:0] address,
    output logic [7:0] data_out,
    output logic       nread,
    output logic       nwrite,
    output logic       halted
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    opcode_u     opcode;
    logic        cond_true;
    logic [2:0]  out1_sel;
    logic [2:0]  out2_sel;
    logic [2:0]  wr_sel;
    logic        write_reg;
    alu_op_e     alu_op;
    bsrc_sel_e   bsrc_sel;
    wdata_sel_e  wdata_sel;
    logic        flag_write;
    logic        pc_increment;
    logic        pc_load;
    logic        inst_write;
    logic        addr_write;
    logic        data_write;
    addr_sel_e   addr_sel;
    logic [7:0]  out1;
    logic [7:0]  out2;
    logic [7:0]  reg_wdata;
    logic [7:0]  alu_b;
    logic [7:0]  alu_result;
    logic [3:0]  alu_flags;
    logic [3:0]  flags;
    logic [7:0]  data_buffer;
    logic [15:0] pc;
    logic [15:0] jump_target;

    assign alu_b = (bsrc_sel == bsrc_sel_data) ? data_buffer : out2;
    assign reg_wdata = (wdata_sel == wdata_sel_bus) ? data_in :
                       (wdata_sel == wdata_sel_alu) ? alu_result : out2;

    control_unit control_unit_i (
        .clock(clock), .rst(rst), .opcode(opcode), .cond_true(cond_true),
        .out1_sel(out1_sel), .out2_sel(out2_sel), .wr_sel(wr_sel), .write_reg(write_reg),
        .alu_op(alu_op), .bsrc_sel(bsrc_sel), .wdata_sel(wdata_sel),
        .flag_write(flag_write), .pc_increment(pc_increment), .pc_load(pc_load),
        .inst_write(inst_write), .addr_write(addr_write), .data_write(data_write),
        .addr_sel(addr_sel), .nread(nread), .nwrite(nwrite), .halted(halted)
    );

    reg_file reg_file_i (
        .clock(clock), .rst(rst), .out1_sel(out1_sel), .out2_sel(out2_sel),
        .wr_sel(wr_sel), .data_in(reg_wdata), .write_reg(write_reg),
        .out1(out1), .out2(out2)
    );

    alu alu_i (
        .a(out1), .b(alu_b), .op(alu_op), .carry_in(flags[flag_c_bit]),
        .result(alu_result), .flags_out(alu_flags)
    );

    program_counter #(.RESET_VECTOR(RESET_VECTOR)) program_counter_i (
        .clock(clock), .rst(rst), .increment(pc_increment), .load(pc_load),
        .load_value(jump_target), .pc(pc)
    );

    bus_datapath bus_datapath_i (
        .clock(clock), .rst(rst), .data_in(data_in), .out2(out2),
        .alu_flags(alu_flags), .pc(pc), .inst_write(inst_write),
        .addr_write(addr_write), .data_write(data_write), .flag_write(flag_write),
        .addr_sel(addr_sel), .opcode(opcode), .data_buffer(data_buffer),
        .address(address), .data_out(data_out), .flags(flags),
        .cond_true(cond_true), .jump_target(jump_target)
    );

endmodule

`default_nettype wire

// File: sim/core_checker.sv
`timescale 1ns/1ns
`default_nettype none

module core_checker #(
    parameter logic [15:0] RESET_VECTOR = 16'h0000
) (
    input wire        clock,
    input wire        rst,
    input wire [15:0] address,
    input wire [7:0]  data_out,
    input wire        nread,
    input wire        nwrite,
    input wire        halted
);
    import isa_pkg::*;

    logic [7:0]  image [65536];   // Copy of memory at program start
    logic [15:0] exp_addr [$];
    logic [7:0]  exp_data [$];
    int          wr_index = 0;
    int          errors = 0;
    int          writes_checked = 0;
    logic        first_read_pending = 1'b0;
    logic        reset_seen = 1'b0;

    // Returns {flags, result} with flags as Z N H C
    function automatic logic [11:0] alu_ref(input logic [2:0] op, input logic [7:0] a,
                                            input logic [7:0] b, input logic cin);
        logic [8:0] w;
        logic [4:0] hw;
        logic [3:0] f;
        logic       ci;
        ci = (op == 3'd1 || op == 3'd3) ? cin : 1'b0;
        f = 4'd0;
        hw = 5'd0;
        if (op <= 3'd1)
        begin
            w = {1'b0, a} + {1'b0, b} + {8'd0, ci};
            hw = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, ci};
            f[flag_c_bit] = w[8];
        end
        else if (op == 3'd4)
        begin
            w = {1'b0, a & b};
            f[flag_h_bit] = 1'b1;
        end
        else if (op == 3'd5)
            w = {1'b0, a ^ b};
        else if (op == 3'd6)
            w = {1'b0, a | b};
        else
        begin
            w = {1'b0, a} - {1'b0, b} - {8'd0, ci};   // Bit 8 is the borrow
            hw = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, ci};
            f[flag_n_bit] = 1'b1;
            f[flag_c_bit] = w[8];
        end
        if (op <= 3'd3 || op == 3'd7)
            f[flag_h_bit] = hw[4];
        f[flag_z_bit] = (w[7:0] == 8'd0);
        return {f, w[7:0]};
    endfunction

    function automatic logic cond_met(input logic [1:0] cc, input logic [3:0] fl);
        case (cc)
            2'd0: return !fl[flag_z_bit];
            2'd1: return fl[flag_z_bit];
            2'd2: return !fl[flag_c_bit];
            default: return fl[flag_c_bit];
        endcase
    endfunction

    // Instruction-set model that runs the image to HALT and lists the bus writes
    function automatic void run_model(input logic [15:0] start);
        logic [7:0]  r [8];
        logic [3:0]  fl;
        logic [15:0] pc;
        logic [15:0] hl;
        logic [7:0]  op;
        logic [7:0]  b;
        logic [11:0] res;
        logic        done;
        int          steps;
        for (int i = 0; i < 8; i++)
            r[i] = 8'd0;
        fl = 4'd0;
        pc = start;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 1000)
        begin
            op = image[pc];
            pc = pc + 16'd1;
            steps++;
            hl = {r[reg_h], r[reg_l]};
            if (op == op_halt)
                done = 1'b1;
            else if (op == op_jp || (op[7:5] == 3'b110 && op[2:0] == 3'b010))
            begin
                b = image[pc];   // High byte first
                pc = pc + 16'd2;
                if (op == op_jp || cond_met(op[4:3], fl))
                    pc = {b, image[pc - 16'd1]};
            end
            else if (op[7:6] == 2'b01 && op[5:3] == reg_mem)
            begin
                exp_addr.push_back(hl);
                exp_data.push_back(r[op[2:0]]);
                image[hl] = r[op[2:0]];
            end
            else if (op[7:6] == 2'b01 && op[2:0] == reg_mem)
                r[op[5:3]] = image[hl];
            else if (op[7:6] == 2'b01)
                r[op[5:3]] = r[op[2:0]];
            else if (op[7:6] == 2'b00 && op[2:0] == reg_mem)
            begin
                r[op[5:3]] = image[pc];
                pc = pc + 16'd1;
            end
            else if (op[7:6] == 2'b10 || (op[7:6] == 2'b11 && op[2:0] == reg_mem))
            begin
                if (op[7:6] == 2'b10)
                    b = r[op[2:0]];
                else
                begin
                    b = image[pc];
                    pc = pc + 16'd1;
                end
                res = alu_ref(op[5:3], r[reg_a], b, fl[flag_c_bit]);
                fl = res[11:8];
                if (op[5:3] != 3'd7)   // Compare keeps A
                    r[reg_a] = res[7:0];
            end
        end
    endfunction

    task automatic prepare();
        exp_addr.delete();
        exp_data.delete();
        wr_index = 0;
        first_read_pending = 1'b1;
        run_model(RESET_VECTOR);
    endtask

    task automatic end_program();
        if (wr_index != exp_addr.size())
        begin
            $display("** Error at %0t: saw %0d bus writes, model expects %0d",
                     $time, wr_index, exp_addr.size());
            errors++;
        end
    endtask

    always @(posedge clock)
        reset_seen <= rst;

    // Bus outputs are stable at the falling edge
    always @(negedge clock)
    begin
        if (rst)
        begin
            if (reset_seen && (!nread || !nwrite || halted))
            begin
                $display("** Error at %0t: strobes or halted active in reset", $time);
                errors++;
            end
        end
        else
        begin
            if (first_read_pending && !nread)
            begin
                first_read_pending = 1'b0;
                if (address != RESET_VECTOR)
                begin
                    $display("** Error at %0t: first read at %h, expected %h",
                             $time, address, RESET_VECTOR);
                    errors++;
                end
            end
            if (halted && (!nread || !nwrite))
            begin
                $display("** Error at %0t: bus access after HALT", $time);
                errors++;
            end
            if (!nwrite)
            begin
                if (wr_index >= exp_addr.size())
                begin
                    $display("** Error at %0t: unexpected write %h <= %h",
                             $time, address, data_out);
                    errors++;
                end
                else if (address != exp_addr[wr_index] || data_out != exp_data[wr_index])
                begin
                    $display("** Error at %0t: write %0d got %h <= %h, expected %h <= %h",
                             $time, wr_index, address, data_out,
                             exp_addr[wr_index], exp_data[wr_index]);
                    errors++;
                end
                wr_index++;
                writes_checked++;
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_core;

    localparam logic [15:0] RESET_VECTOR = 16'h0100;
    localparam int PROGRAMS = 3;
    localparam int PROG_LEN = 40;
    localparam int TIMEOUT_CYCLES = PROGRAMS * (PROG_LEN + 1) * 4 + 100;

    logic        clock;
    logic        rst;
    logic [7:0]  data_in;
    logic [15:0] address;
    logic [7:0]  data_out;
    logic        nread;
    logic        nwrite;
    logic        halted;
    logic [7:0]  mem [65536];
    integer      seed;
    int          cycles;

    cpu_core #(.RESET_VECTOR(RESET_VECTOR)) dut_i (
        .clock(clock), .rst(rst), .data_in(data_in), .address(address),
        .data_out(data_out), .nread(nread), .nwrite(nwrite), .halted(halted)
    );

    core_checker #(.RESET_VECTOR(RESET_VECTOR)) checker_i (
        .clock(clock), .rst(rst), .address(address), .data_out(data_out),
        .nread(nread), .nwrite(nwrite), .halted(halted)
    );

    always #10 clock = ~clock;

    // Memory answers within the cycle
    always @(posedge clock)
    begin
        #2;
        data_in = mem[address];
    end

    always @(negedge clock)
    begin
        if (!rst && !nwrite)
            mem[address] = data_out;
    end

    always @(posedge clock)
    begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES)
        begin
            $display("Timeout: core did not halt within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic int unsigned rand_below(input int unsigned n);
        logic [31:0] v;
        v = $random(seed);
        return v % n;
    endfunction

    // Any register but the (HL) slot
    function automatic logic [2:0] pick_src();
        logic [2:0] t;
        t = 3'(rand_below(7));
        return (t == 3'd6) ? 3'd7 : t;
    endfunction

    // B C D E or A, so HL stays in the data region
    function automatic logic [2:0] pick_dst();
        logic [2:0] t;
        t = 3'(rand_below(5));
        return (t == 3'd4) ? 3'd7 : t;
    endfunction

    function automatic int len_of(input int kind);
        if (kind == 1 || kind == 3)
            return 2;
        if (kind >= 6)
            return 3;
        return 1;
    endfunction

    task automatic fill_memory(input int prog);
        logic [15:0] a;
        for (int i = 0; i < 65536; i++)
        begin
            a = 16'(i);
            mem[a] = a[7:0] ^ (a[15:8] * 8'd13) ^ 8'(prog * 29);
        end
    endtask

    task automatic build_program();
        logic [15:0] start [PROG_LEN + 1];
        logic [7:0]  ops [PROG_LEN + 1];
        logic [7:0]  arg [PROG_LEN + 1];
        int          kinds [PROG_LEN + 1];
        logic [15:0] a;
        int          tgt;
        a = RESET_VECTOR;
        for (int i = 0; i <= PROG_LEN; i++)
        begin
            start[i] = a;
            arg[i] = 8'(rand_below(256));
            kinds[i] = (i < 2) ? 1 : int'(rand_below(10));
            if (kinds[i] >= 8)
                kinds[i] = 4;   // Extra stores make results visible
            case (kinds[i])
                0: ops[i] = {2'b01, pick_dst(), pick_src()};
                1: ops[i] = {2'b00, (rand_below(4) == 0) ? 3'd5 : pick_dst(), 3'b110};
                2: ops[i] = {2'b10, 3'(rand_below(8)), pick_src()};
                3: ops[i] = {2'b11, 3'(rand_below(8)), 3'b110};
                4: ops[i] = {5'b01110, pick_src()};
                5: ops[i] = {2'b01, pick_dst(), 3'b110};
                6: ops[i] = 8'hc3;
                default: ops[i] = {3'b110, 2'(rand_below(4)), 3'b010};
            endcase
            if (i == 0)
            begin
                ops[i] = 8'h26;   // LD H,80
                arg[i] = 8'h80;
            end
            else if (i == 1)
                ops[i] = 8'h2e;
            else if (i == PROG_LEN)
            begin
                ops[i] = 8'h76;
                kinds[i] = 0;
            end
            a = a + 16'(len_of(kinds[i]));
        end
        for (int i = 0; i <= PROG_LEN; i++)
        begin
            mem[start[i]] = ops[i];
            if (len_of(kinds[i]) == 2)
                mem[start[i] + 16'd1] = arg[i];
            else if (len_of(kinds[i]) == 3)
            begin
                tgt = i + 1 + int'(rand_below(32'(PROG_LEN - i)));
                mem[start[i] + 16'd1] = start[tgt][15:8];
                mem[start[i] + 16'd2] = start[tgt][7:0];
            end
        end
    endtask

    initial
    begin
        clock = 1'b0;
        rst = 1'b1;
        data_in = 8'd0;
        seed = 99246;
        cycles = 0;
        for (int p = 0; p < PROGRAMS; p++)
        begin
            if (p > 0)
            begin
                @(posedge clock);
                #2;
                rst = 1'b1;
            end
            fill_memory(p);
            build_program();
            for (int i = 0; i < 65536; i++)
                checker_i.image[16'(i)] = mem[16'(i)];
            checker_i.prepare();
            repeat (2) @(posedge clock);
            #2;
            rst = 1'b0;
            @(negedge clock);
            while (!halted)
                @(negedge clock);
            repeat (3) @(negedge clock);   // Bus must stay quiet
            checker_i.end_program();
        end
        $display("Summary: %0d bus writes checked, %0d errors",
                 checker_i.writes_checked, checker_i.errors);
        if (checker_i.errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
verilog/isa_pkg.sv
verilog/ctrl_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/program_counter.sv
verilog/control_unit.sv
verilog/bus_datapath.sv
verilog/cpu_core.sv
sim/core_checker.sv
sim/tb_cpu_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_cpu_core
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
